/* logic/ahb_burst_pkg.sv */
package ahb_burst_pkg;

    localparam int DATA_W     = 32;
    localparam int MAX_BEATS  = 8;                       // Words in the write data block
    localparam int BEAT_CNT_W = $clog2(MAX_BEATS + 1);   // Holds 0 to MAX_BEATS

    // Transfer type
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    // Burst codes, the unsupported ones stay for a complete decode
    typedef enum logic [2:0] {
        BURST_SINGLE = 3'b000,
        BURST_INCR   = 3'b001,
        BURST_WRAP4  = 3'b010,
        BURST_INCR4  = 3'b011,
        BURST_WRAP8  = 3'b100,
        BURST_INCR8  = 3'b101,
        BURST_WRAP16 = 3'b110,
        BURST_INCR16 = 3'b111
    } hburst_t;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'b000,
        SIZE_HALF = 3'b001,
        SIZE_WORD = 3'b010
    } hsize_t;

    typedef enum logic [1:0] {
        RESP_OKAY  = 2'b00,
        RESP_ERROR = 2'b01,
        RESP_RETRY = 2'b10,
        RESP_SPLIT = 2'b11
    } hresp_t;

    // Word 0 sits in the low bits
    typedef logic [MAX_BEATS-1:0][DATA_W-1:0] wdata_block_t;

    // Beats in one burst
    function automatic logic [BEAT_CNT_W-1:0] burst_beats(hburst_t burst);
        case (burst)
            BURST_WRAP4, BURST_INCR4: return BEAT_CNT_W'(4);
            BURST_WRAP8, BURST_INCR8: return BEAT_CNT_W'(8);
            default:                  return BEAT_CNT_W'(1);
        endcase
    endfunction

    function automatic logic burst_is_wrap(hburst_t burst);
        case (burst)
            BURST_WRAP4, BURST_WRAP8, BURST_WRAP16: return 1'b1;
            default:                                return 1'b0;
        endcase
    endfunction

endpackage

/* logic/burst_seq_if.sv */
`timescale 1ns/100ps

// Sequencer to datapath handshake, all signals describe the next bus cycle
interface burst_seq_if;
    import ahb_burst_pkg::*;

    logic                  req;          // Bus request pending
    logic                  load;         // First address phase issued
    logic                  addr_adv;     // Address accepted, another follows
    logic                  addr_active;
    logic                  first;        // First beat of the burst
    logic                  data_active;  // Write data phase in progress
    logic [BEAT_CNT_W-1:0] data_idx;
    logic                  finish;       // Burst ends, done or aborted

    modport seq (
        output req, load, addr_adv, addr_active, first, data_active, data_idx, finish
    );

    modport addr (
        input load, addr_adv, finish
    );

    modport drive (
        input req, load, addr_active, first, data_active, data_idx, finish
    );

endinterface

/* logic/burst_sequencer.sv */
`timescale 1ns/100ps

module burst_sequencer (
    input  logic                   hclk,
    input  logic                   hresetn,
    input  logic                   trans_en,
    input  logic                   new_trans,
    input  logic                   hgrant,
    input  logic                   hready,
    input  ahb_burst_pkg::hresp_t  hresp,
    input  ahb_burst_pkg::hburst_t hburst,
    input  logic                   hwrite,
    output logic                   trans_finish,
    burst_seq_if.seq               seq
);
    import ahb_burst_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        GRANT,
        TRANSMIT,
        DONE
    } state_t;

    state_t state, state_nxt;

    logic [BEAT_CNT_W-1:0] beats;
    logic [BEAT_CNT_W-1:0] addr_cnt, addr_cnt_nxt;   // Accepted address phases
    logic [BEAT_CNT_W-1:0] data_cnt, data_cnt_nxt;   // Completed data phases
    logic                  in_xfer;
    logic                  addr_pend;
    logic                  data_pend;
    logic                  abort;
    logic                  addr_take;
    logic                  data_take;
    logic                  last_done;

    assign beats     = burst_beats(hburst);
    assign in_xfer   = (state == TRANSMIT);
    assign addr_pend = in_xfer && (addr_cnt < beats);     // Address phase on the bus
    assign data_pend = in_xfer && (data_cnt < addr_cnt);  // Data phase on the bus

    // A response only counts while a data phase is out
    assign abort = !trans_en || (data_pend && (hresp != RESP_OKAY));

    assign addr_take = addr_pend && hready && !abort;
    assign data_take = data_pend && hready && !abort;

    assign addr_cnt_nxt = addr_cnt + BEAT_CNT_W'(addr_take);
    assign data_cnt_nxt = data_cnt + BEAT_CNT_W'(data_take);
    assign last_done    = in_xfer && !abort && (data_cnt_nxt == beats);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (new_trans && trans_en) state_nxt = REQ;
            REQ: begin
                if (!trans_en) begin
                    state_nxt = DONE;
                end else if (hgrant) begin
                    state_nxt = GRANT;
                end
            end
            GRANT:    state_nxt = trans_en ? TRANSMIT : DONE;
            TRANSMIT: if (abort || last_done) state_nxt = DONE;
            DONE:     state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state        <= IDLE;
            addr_cnt     <= '0;
            data_cnt     <= '0;
            trans_finish <= 1'b0;
        end else begin
            state        <= state_nxt;
            trans_finish <= (state == DONE);
            if (in_xfer) begin
                addr_cnt <= addr_cnt_nxt;
                data_cnt <= data_cnt_nxt;
            end else begin
                addr_cnt <= '0;  // Fresh count for every burst
                data_cnt <= '0;
            end
        end
    end

    // Datapath controls for the coming bus cycle
    assign seq.req         = (state == REQ);
    assign seq.load        = (state == GRANT) && trans_en;
    assign seq.addr_adv    = addr_take && (addr_cnt_nxt < beats);
    assign seq.addr_active = seq.load || (in_xfer && !abort && (addr_cnt_nxt < beats));
    assign seq.first       = seq.addr_active && (addr_cnt_nxt == '0);
    assign seq.data_active = hwrite && in_xfer && !abort && (data_cnt_nxt < addr_cnt_nxt);
    assign seq.data_idx    = data_cnt_nxt;
    assign seq.finish      = (state == DONE);

endmodule

/* logic/burst_addr_gen.sv */
`timescale 1ns/100ps

module burst_addr_gen #(
    parameter int ADDR_W = 32
) (
    input  logic                   hclk,
    input  logic                   hresetn,
    input  logic [ADDR_W-1:0]      haddr_start,
    input  ahb_burst_pkg::hsize_t  hsize,
    input  ahb_burst_pkg::hburst_t hburst,
    output logic [ADDR_W-1:0]      haddr,
    burst_seq_if.addr              seq
);
    import ahb_burst_pkg::*;

    logic [1:0]        size_shift;  // log2 of bytes per beat
    logic [ADDR_W-1:0] step;
    logic [ADDR_W-1:0] boundary;
    logic [ADDR_W-1:0] wrap_mask;
    logic [ADDR_W-1:0] addr_inc;
    logic [ADDR_W-1:0] addr_nxt;

    always_comb begin
        case (hsize)
            SIZE_BYTE: size_shift = 2'd0;
            SIZE_HALF: size_shift = 2'd1;
            default:   size_shift = 2'd2;
        endcase
    end

    assign step     = ADDR_W'(1) << size_shift;
    assign boundary = ADDR_W'(burst_beats(hburst)) << size_shift;  // Beats times bytes
    assign addr_inc = haddr + step;

    // Wrapping keeps everything above the boundary
    always_comb begin
        wrap_mask = boundary - ADDR_W'(1);
        if (burst_is_wrap(hburst)) begin
            addr_nxt = (haddr & ~wrap_mask) | (addr_inc & wrap_mask);
        end else begin
            addr_nxt = addr_inc;
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            haddr <= '0;
        end else if (seq.load) begin
            haddr <= haddr_start;
        end else if (seq.addr_adv) begin
            haddr <= addr_nxt;
        end else if (seq.finish) begin
            haddr <= '0;
        end
    end

    // Under wait states neither pulse comes, so haddr holds

endmodule

/* logic/bus_signal_drive.sv */
`timescale 1ns/100ps

module bus_signal_drive (
    input  logic                                  hclk,
    input  logic                                  hresetn,
    input  logic                                  hwrite_in,
    input  ahb_burst_pkg::hsize_t                 hsize_in,
    input  ahb_burst_pkg::hburst_t                hburst_in,
    input  ahb_burst_pkg::wdata_block_t           wdata,
    output logic                                  hbusreq,
    output logic                                  hlock,
    output ahb_burst_pkg::htrans_t                htrans,
    output logic                                  hwrite,
    output ahb_burst_pkg::hsize_t                 hsize,
    output ahb_burst_pkg::hburst_t                hburst,
    output logic [ahb_burst_pkg::DATA_W-1:0]      hwdata,
    burst_seq_if.drive                            seq
);
    import ahb_burst_pkg::*;

    localparam int IDX_W = $clog2(MAX_BEATS);

    logic [IDX_W-1:0]  word_sel;
    logic [DATA_W-1:0] word;
    htrans_t           htrans_nxt;

    assign word_sel = seq.data_idx[IDX_W-1:0];
    assign word     = wdata[word_sel];

    always_comb begin
        if (!seq.addr_active) begin
            htrans_nxt = HTRANS_IDLE;
        end else if (seq.first) begin
            htrans_nxt = HTRANS_NONSEQ;
        end else begin
            htrans_nxt = HTRANS_SEQ;
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            hbusreq <= 1'b0;
            hlock   <= 1'b0;
            htrans  <= HTRANS_IDLE;
            hwrite  <= 1'b0;
            hsize   <= SIZE_BYTE;
            hburst  <= BURST_SINGLE;
        end else begin
            htrans <= htrans_nxt;

            // Request and lock stay up for the whole burst
            if (seq.finish) begin
                hbusreq <= 1'b0;
                hlock   <= 1'b0;
            end else if (seq.req) begin
                hbusreq <= 1'b1;
                hlock   <= 1'b1;
            end

            if (seq.load) begin
                hwrite <= hwrite_in;
                hsize  <= hsize_in;
                hburst <= hburst_in;
            end else if (seq.finish) begin
                hwrite <= 1'b0;  // Back to read when idle
                hsize  <= SIZE_BYTE;
                hburst <= BURST_SINGLE;
            end
        end
    end

    // Write data follows its address phase by one cycle
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            hwdata <= '0;
        end else if (seq.data_active) begin
            hwdata <= word;
        end else begin
            hwdata <= '0;
        end
    end

endmodule

/* logic/ahb_burst_master.sv */
`timescale 1ns/100ps

module ahb_burst_master #(
    parameter int ADDR_W = 32
) (
    input  logic                             hclk,
    input  logic                             hresetn,
    input  logic                             trans_en,
    input  logic                             new_trans,
    input  logic                             hgrant,
    input  logic                             hready,
    input  logic [ADDR_W-1:0]                haddr_start,
    input  logic                             hwrite_in,
    input  ahb_burst_pkg::hsize_t            hsize_in,
    input  ahb_burst_pkg::hburst_t           hburst_in,
    input  ahb_burst_pkg::hresp_t            hresp,
    input  ahb_burst_pkg::wdata_block_t      wdata,
    output logic                             hbusreq,
    output logic                             hlock,
    output ahb_burst_pkg::htrans_t           htrans,
    output logic [ADDR_W-1:0]                haddr,
    output logic                             hwrite,
    output ahb_burst_pkg::hsize_t            hsize,
    output ahb_burst_pkg::hburst_t           hburst,
    output logic [ahb_burst_pkg::DATA_W-1:0] hwdata,
    output logic                             trans_finish
);

    burst_seq_if u_seq_if ();

    // Burst FSM, the only place that looks at hready and hresp
    burst_sequencer u_sequencer (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .trans_en     (trans_en),
        .new_trans    (new_trans),
        .hgrant       (hgrant),
        .hready       (hready),
        .hresp        (hresp),
        .hburst       (hburst_in),
        .hwrite       (hwrite_in),
        .trans_finish (trans_finish),
        .seq          (u_seq_if.seq)
    );

    burst_addr_gen #(
        .ADDR_W (ADDR_W)
    ) u_addr_gen (
        .hclk        (hclk),
        .hresetn     (hresetn),
        .haddr_start (haddr_start),
        .hsize       (hsize_in),
        .hburst      (hburst_in),
        .haddr       (haddr),
        .seq         (u_seq_if.addr)
    );

    bus_signal_drive u_drive (
        .hclk      (hclk),
        .hresetn   (hresetn),
        .hwrite_in (hwrite_in),
        .hsize_in  (hsize_in),
        .hburst_in (hburst_in),
        .wdata     (wdata),
        .hbusreq   (hbusreq),
        .hlock     (hlock),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hsize     (hsize),
        .hburst    (hburst),
        .hwdata    (hwdata),
        .seq       (u_seq_if.drive)
    );

endmodule

/* include/burst_ref.svh */
`ifndef BURST_REF_SVH
`define BURST_REF_SVH

// Expected number of beats for a burst code
function automatic int unsigned ref_beat_count(ahb_burst_pkg::hburst_t burst);
    case (burst)
        ahb_burst_pkg::BURST_INCR4, ahb_burst_pkg::BURST_WRAP4: return 4;
        ahb_burst_pkg::BURST_INCR8, ahb_burst_pkg::BURST_WRAP8: return 8;
        default:                                                return 1;
    endcase
endfunction

// Address of beat k, wrapping inside beats times bytes when the burst wraps
function automatic logic [31:0] ref_beat_addr(
    logic [31:0]            start,
    ahb_burst_pkg::hsize_t  size,
    ahb_burst_pkg::hburst_t burst,
    int unsigned            k
);
    logic [31:0] bytes;
    logic [31:0] boundary;
    logic [31:0] lin;
    bytes = 32'd1 << size;
    lin   = start + k * bytes;
    if (burst inside {ahb_burst_pkg::BURST_WRAP4, ahb_burst_pkg::BURST_WRAP8}) begin
        boundary = ref_beat_count(burst) * bytes;
        return (start & ~(boundary - 32'd1)) | (lin % boundary);
    end
    return lin;
endfunction

// Write data expected on beat k
function automatic logic [ahb_burst_pkg::DATA_W-1:0] ref_beat_data(
    ahb_burst_pkg::wdata_block_t block,
    int unsigned                 k
);
    logic [ahb_burst_pkg::DATA_W-1:0] word;
    word = '0;
    if (k < ahb_burst_pkg::MAX_BEATS) begin
        word = block[k];
    end
    return word;
endfunction

`endif

/* bench/tb_ahb_burst_master.sv */
`timescale 1ns/100ps

module tb_ahb_burst_master;
    import ahb_burst_pkg::*;

    `include "burst_ref.svh"

    localparam int      NUM_TESTS  = 52;
    localparam realtime CLK_PERIOD = 8.0;
    localparam int      MAX_CYCLES = 400;   // Per burst

    logic         hclk;
    logic         hresetn;
    logic         trans_en;
    logic         new_trans;
    logic         hgrant;
    logic         hready;
    logic [31:0]  haddr_start;
    logic         hwrite_in;
    hsize_t       hsize_in;
    hburst_t      hburst_in;
    hresp_t       hresp;
    wdata_block_t wdata;
    logic         hbusreq;
    logic         hlock;
    htrans_t      htrans;
    logic [31:0]  haddr;
    logic         hwrite;
    hsize_t       hsize;
    hburst_t      hburst;
    logic [31:0]  hwdata;
    logic         trans_finish;

    // Slave model records
    logic [31:0] addr_q[$];
    htrans_t     trans_q[$];
    logic [31:0] data_q[$];
    int          fin_cnt;
    bit          finished;
    bit          stall_en;
    int          abort_beat;         // Data beat that gets the error or -1
    hresp_t      abort_resp;
    bit          abort_used;
    bit          abort_now;
    bit          resp_tail;
    bit          data_pend;
    bit          data_wr;
    int          data_done_cnt;
    bit          hold_pend;
    logic [31:0] prev_addr;
    htrans_t     prev_trans;
    logic [31:0] prev_wdata;
    int          grant_wait;

    // Current burst as seen by the compare process
    string       test_name;
    logic [31:0] cur_start;
    logic        cur_write;
    hsize_t      cur_size;
    hburst_t     cur_burst;
    int          cur_mode;           // 0 full, 1 response abort, 2 enable drop
    event        burst_done;
    bit          compare_done;

    ahb_burst_master #(
        .ADDR_W (32)
    ) u_dut (
        .hclk         (hclk),
        .hresetn      (hresetn),
        .trans_en     (trans_en),
        .new_trans    (new_trans),
        .hgrant       (hgrant),
        .hready       (hready),
        .haddr_start  (haddr_start),
        .hwrite_in    (hwrite_in),
        .hsize_in     (hsize_in),
        .hburst_in    (hburst_in),
        .hresp        (hresp),
        .wdata        (wdata),
        .hbusreq      (hbusreq),
        .hlock        (hlock),
        .htrans       (htrans),
        .haddr        (haddr),
        .hwrite       (hwrite),
        .hsize        (hsize),
        .hburst       (hburst),
        .hwdata       (hwdata),
        .trans_finish (trans_finish)
    );

    initial begin
        hclk = 1'b0;
        forever #(CLK_PERIOD / 2) hclk = ~hclk;
    end

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(bit cond, string what);
        assert (cond) else begin
            $display("Error: %s", what);
            $display("FAIL: see errors above");
            $fatal(1, "check failed");
        end
    endtask

    // Arbiter grants 0 to 3 cycles after the request
    always @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            hgrant     <= 1'b0;
            grant_wait <= 0;
        end else if (!hbusreq) begin
            hgrant     <= 1'b0;
            grant_wait <= int'($urandom % 4);
        end else if (grant_wait == 0) begin
            hgrant <= 1'b1;
        end else begin
            grant_wait <= grant_wait - 1;
        end
    end

    // Slave samples at the falling edge and drives at the rising edge
    always begin : slave_model
        bit go_abort;
        @(negedge hclk);
        go_abort = 1'b0;
        if (hresetn) begin
            if (hold_pend) begin
                check_value({test_name, " stalled haddr"}, prev_addr, haddr);
                check_value({test_name, " stalled htrans"}, 32'(prev_trans), 32'(htrans));
                check_value({test_name, " stalled hwdata"}, prev_wdata, hwdata);
            end
            if (abort_now) begin
                data_pend = 1'b0;   // Errored beat never completes
                abort_now = 1'b0;
                resp_tail = 1'b1;
            end else if (hready) begin
                if (data_pend) begin
                    if (data_wr) data_q.push_back(hwdata);
                    data_done_cnt++;
                    data_pend = 1'b0;
                end
                if (htrans != HTRANS_IDLE) begin
                    check_value({test_name, " hwrite"}, 32'(cur_write), 32'(hwrite));
                    check_value({test_name, " hsize"}, 32'(cur_size), 32'(hsize));
                    check_value({test_name, " hburst"}, 32'(cur_burst), 32'(hburst));
                    addr_q.push_back(haddr);
                    trans_q.push_back(htrans);
                    data_pend = 1'b1;
                    data_wr   = hwrite;
                end
            end
            hold_pend = !hready && (hresp == RESP_OKAY) && trans_en &&
                        ((htrans != HTRANS_IDLE) || data_pend);
            prev_addr  = haddr;
            prev_trans = htrans;
            prev_wdata = hwdata;
            if (finished) begin
                check_true(htrans == HTRANS_IDLE, "transfer driven after trans_finish");
            end
            if (trans_finish) begin
                fin_cnt++;
                finished = 1'b1;
            end
            go_abort = (abort_beat >= 0) && data_pend && !abort_used &&
                       (data_done_cnt == abort_beat);
        end
        @(posedge hclk);
        if (go_abort) begin
            hready    <= 1'b0;    // First cycle of a two-cycle response
            hresp     <= abort_resp;
            abort_used = 1'b1;
            abort_now  = 1'b1;
        end else if (resp_tail) begin
            hready    <= 1'b1;    // Second cycle ends the response
            hresp     <= abort_resp;
            resp_tail  = 1'b0;
        end else begin
            hready <= (stall_en && hresetn) ? ($urandom % 3 != 0) : 1'b1;
            hresp  <= RESP_OKAY;
        end
    end

    // Compare process runs once per burst
    always begin : compare_proc
        int n;
        @(burst_done);
        n = int'(ref_beat_count(cur_burst));
        check_value({test_name, " finish pulses"}, 32'd1, 32'(fin_cnt));
        check_value({test_name, " hbusreq"}, 32'd0, 32'(hbusreq));
        check_value({test_name, " hlock"}, 32'd0, 32'(hlock));
        check_value({test_name, " htrans idle"}, 32'(HTRANS_IDLE), 32'(htrans));
        if (cur_mode == 0) begin
            check_value({test_name, " address beats"}, 32'(n), 32'(addr_q.size()));
            check_value({test_name, " data beats"}, cur_write ? 32'(n) : 32'd0,
                        32'(data_q.size()));
        end else begin
            check_true(addr_q.size() <= n, {test_name, ": more beats than the burst holds"});
        end
        foreach (addr_q[i]) begin
            check_value($sformatf("%s beat %0d addr", test_name, i),
                        ref_beat_addr(cur_start, cur_size, cur_burst, i), addr_q[i]);
            check_value($sformatf("%s beat %0d htrans", test_name, i),
                        (i == 0) ? 32'(HTRANS_NONSEQ) : 32'(HTRANS_SEQ), 32'(trans_q[i]));
        end
        if (cur_mode != 2) begin
            foreach (data_q[i]) begin
                check_value($sformatf("%s beat %0d data", test_name, i),
                            ref_beat_data(wdata, i), data_q[i]);
            end
        end
        compare_done = 1'b1;
    end

    task automatic run_burst(string name, logic [31:0] start, logic wr, hsize_t sz,
                             hburst_t bt, bit stall, int abort_at, int drop_at);
        int cycles;
        test_name     = name;
        cur_start     = start;
        cur_write     = wr;
        cur_size      = sz;
        cur_burst     = bt;
        cur_mode      = (abort_at >= 0) ? 1 : ((drop_at >= 0) ? 2 : 0);
        addr_q.delete();
        trans_q.delete();
        data_q.delete();
        fin_cnt       = 0;
        finished      = 1'b0;
        data_done_cnt = 0;
        abort_beat    = abort_at;
        abort_used    = 1'b0;
        stall_en      = stall;
        case ($urandom % 3)
            0:       abort_resp = RESP_ERROR;
            1:       abort_resp = RESP_RETRY;
            default: abort_resp = RESP_SPLIT;
        endcase
        @(posedge hclk);
        for (int w = 0; w < MAX_BEATS; w++) begin
            wdata[w] <= $urandom;
        end
        haddr_start <= start;
        hwrite_in   <= wr;
        hsize_in    <= sz;
        hburst_in   <= bt;
        trans_en    <= 1'b1;
        new_trans   <= 1'b1;
        @(posedge hclk);
        new_trans <= 1'b0;
        cycles = 0;
        while (fin_cnt == 0 && cycles < MAX_CYCLES) begin
            @(posedge hclk);
            cycles++;
            if (drop_at >= 0 && addr_q.size() > drop_at) trans_en <= 1'b0;
        end
        check_true(fin_cnt != 0, {name, ": burst never signalled trans_finish"});
        repeat (4) @(posedge hclk);   // Let a second pulse show up if there is one
        stall_en = 1'b0;
        trans_en <= 1'b1;
        compare_done = 1'b0;
        -> burst_done;
        wait (compare_done);
    endtask

    initial begin : main_seq
        hburst_t     incr_kinds[3];
        hburst_t     wrap_kinds[2];
        hburst_t     all_kinds[5];
        hburst_t     bt;
        hsize_t      sz;
        logic [31:0] bytes;
        logic [31:0] bnd;
        logic [31:0] base;
        int          seed_val;
        seed_val    = int'($urandom(32'h30d4_4438));
        incr_kinds  = '{BURST_SINGLE, BURST_INCR4, BURST_INCR8};
        wrap_kinds  = '{BURST_WRAP4, BURST_WRAP8};
        all_kinds   = '{BURST_SINGLE, BURST_INCR4, BURST_INCR8, BURST_WRAP4, BURST_WRAP8};
        hresetn     = 1'b0;
        trans_en    = 1'b0;
        new_trans   = 1'b0;
        hgrant      = 1'b0;
        hready      = 1'b1;
        hresp       = RESP_OKAY;
        haddr_start = '0;
        hwrite_in   = 1'b0;
        hsize_in    = SIZE_BYTE;
        hburst_in   = BURST_SINGLE;
        wdata       = '0;
        abort_beat  = -1;
        test_name   = "reset";
        repeat (8) @(posedge hclk);
        hresetn <= 1'b1;
        repeat (2) @(negedge hclk);
        check_value("reset hbusreq", 32'd0, 32'(hbusreq));
        check_value("reset hlock", 32'd0, 32'(hlock));
        check_value("reset trans_finish", 32'd0, 32'(trans_finish));
        check_value("reset htrans", 32'(HTRANS_IDLE), 32'(htrans));
        check_value("reset haddr", 32'd0, haddr);

        foreach (incr_kinds[b]) begin
            for (int s = 0; s < 3; s++) begin
                for (int w = 0; w < 2; w++) begin
                    sz    = hsize_t'(s);
                    bytes = 32'd1 << s;
                    run_burst($sformatf("incr %s size %0d wr %0d", incr_kinds[b].name(), s, w),
                              $urandom & ~(bytes - 32'd1), w[0], sz, incr_kinds[b], 1'b0, -1, -1);
                end
            end
        end

        foreach (wrap_kinds[b]) begin
            for (int s = 0; s < 3; s++) begin
                sz    = hsize_t'(s);
                bytes = 32'd1 << s;
                bnd   = 32'(ref_beat_count(wrap_kinds[b])) * bytes;
                base  = $urandom & ~(bnd - 32'd1);
                run_burst($sformatf("wrap %s size %0d on", wrap_kinds[b].name(), s),
                          base, 1'b1, sz, wrap_kinds[b], 1'b0, -1, -1);
                run_burst($sformatf("wrap %s size %0d near", wrap_kinds[b].name(), s),
                          base | (bnd - bytes), 1'b0, sz, wrap_kinds[b], 1'b0, -1, -1);
            end
        end

        // Same reference with stalls and late grants
        for (int t = 0; t < 12; t++) begin
            bt    = all_kinds[$urandom % 5];
            sz    = hsize_t'($urandom % 3);
            bytes = 32'd1 << sz;
            run_burst($sformatf("stall %0d %s", t, bt.name()), $urandom & ~(bytes - 32'd1),
                      1'($urandom), sz, bt, 1'b1, -1, -1);
        end

        for (int t = 0; t < 6; t++) begin
            bt    = all_kinds[1 + ($urandom % 4)];
            sz    = hsize_t'($urandom % 3);
            bytes = 32'd1 << sz;
            run_burst($sformatf("abort %0d %s", t, bt.name()), $urandom & ~(bytes - 32'd1),
                      1'b1, sz, bt, 1'($urandom), int'($urandom % ref_beat_count(bt)), -1);
        end

        for (int t = 0; t < 2; t++) begin
            run_burst($sformatf("drop %0d", t), $urandom & ~32'd3, 1'b1, SIZE_WORD,
                      BURST_INCR8, 1'b1, -1, 1 + t);
            run_burst($sformatf("after drop %0d", t), $urandom & ~32'd1, 1'b1, SIZE_HALF,
                      BURST_WRAP8, 1'b0, -1, -1);
        end

        $display("PASS: all tests");
        $finish;
    end

    // Watchdog sized for eight beats of twenty cycles per test
    initial begin : watchdog
        #(NUM_TESTS * 8 * 20 * CLK_PERIOD);
        $display("Error: watchdog expired before the tests completed");
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

endmodule

/* project.f */
+incdir+include
logic/ahb_burst_pkg.sv
logic/burst_seq_if.sv
logic/burst_sequencer.sv
logic/burst_addr_gen.sv
logic/bus_signal_drive.sv
logic/ahb_burst_master.sv
bench/tb_ahb_burst_master.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f project.f --top-module tb_ahb_burst_master -Mdir obj_dir
	./obj_dir/Vtb_ahb_burst_master 2>&1 | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
